// File: ncsi_ipt.f
+incdir+logic
logic/ipt_bus_pkg.sv
logic/ipt_buf_pkg.sv
logic/ipt_rx_writer.sv
logic/ipt_pkt_ram.sv
logic/ipt_tx_reader.sv
logic/ncsi_ipt.sv
dv/ncsi_ipt_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ncsi_ipt testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -Ilogic \
   --top-module ncsi_ipt_tb -f ncsi_ipt.f -o ncsi_ipt_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ncsi_ipt_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
   exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
   echo "no pass message in log"
   exit 1
fi
exit 0

// File: dv/ncsi_ipt_tb.sv
// Testbench for the NC-SI ingress passthrough block
// Beats are checked by concurrent assertions against an expected queue
// Expected beats assume the buffer is drained before each drop or full test
`timescale 1ns/1ps
`include "ipt_defs.svh"

module ncsi_ipt_tb
   import ipt_bus_pkg::*, ipt_buf_pkg::*;
();

   // Rough word count of all tests, times a generous cycle bound per word
   localparam int PLAN_WORDS      = 2 * (23 + 14 + 211 + 54 + 283);
   localparam int CYCLES_PER_WORD = 40;
   localparam int TIMEOUT_NS      = PLAN_WORDS * CYCLES_PER_WORD * 100;

   logic        clk = 1'b0;
   logic        reset;
   avmm_req_t   req;
   logic        waitreq;
   logic        ch_en;
   logic        lpbk_en;
   st_beat_t    beat;
   logic        arb_vld;
   logic        arb_rdy;
   logic        lpbk_vld;
   logic        lpbk_rdy;
   logic        xfer;
   st_beat_t    exp_q[$];
   logic        exp_port_q[$];
   st_beat_t    exp_head = '0;
   logic        exp_head_lpbk = 1'b0;
   int          exp_cnt = 0;
   string       test_name = "reset";
   int          mism_errs = 0;
   int          other_errs = 0;
   logic        rand_rdy = 1'b0;
   logic [31:0] rdy_rng = 32'h2f49_376d;
   logic [31:0] len_rng;
   int          pkt_num = 0;

   ncsi_ipt ncsi_ipt_inst (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .waitreq  (waitreq),
      .ch_en    (ch_en),
      .lpbk_en  (lpbk_en),
      .beat     (beat),
      .arb_vld  (arb_vld),
      .arb_rdy  (arb_rdy),
      .lpbk_vld (lpbk_vld),
      .lpbk_rdy (lpbk_rdy)
   );

   always #50 clk = ~clk;

   assign xfer = (arb_vld && arb_rdy) || (lpbk_vld && lpbk_rdy);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Disabled bytes at the low end of a 32-bit half
   function automatic mod_t trailing_empty(input logic [3:0] be);
      int n;
      n = 0;
      while (n < 4 && !be[n])
         n++;
      return mod_t'(n);
   endfunction

   //------------------------------------------------------------------------
   // Expected queue head, refreshed after each transfer
   //------------------------------------------------------------------------
   always @(posedge clk) begin
      if (xfer && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         void'(exp_port_q.pop_front());
      end
      if (exp_q.size() > 0) begin
         exp_head      <= exp_q[0];
         exp_head_lpbk <= exp_port_q[0];
      end
      exp_cnt <= exp_q.size();
   end

   // Random ready on both ports, only the selected one matters
   always @(negedge clk) begin
      if (rand_rdy) begin
         rdy_rng  = xorshift32(rdy_rng);
         arb_rdy  = rdy_rng[0];
         lpbk_rdy = rdy_rng[1];
      end
   end

   //------------------------------------------------------------------------
   // Checks
   //------------------------------------------------------------------------
   a_reset_quiet: assert property (@(posedge clk)
      reset |-> (waitreq && !arb_vld && !lpbk_vld))
      else begin
         other_errs++;
         $display("error in %s: waitreq low or a valid high during reset", test_name);
      end

   a_reset_after: assert property (@(posedge clk)
      $fell(reset) |-> (waitreq && !arb_vld && !lpbk_vld))
      else begin
         other_errs++;
         $display("error in %s: outputs not quiet in first cycle after reset", test_name);
      end

   a_expected: assert property (@(posedge clk) disable iff (reset)
      xfer |-> (exp_cnt > 0))
      else begin
         other_errs++;
         $display("error in %s: beat transferred while none was expected", test_name);
      end

   a_beat_value: assert property (@(posedge clk) disable iff (reset)
      (xfer && exp_cnt > 0) |-> (beat == exp_head))
      else begin
         mism_errs++;
         $display("mismatch %s beat expected %h actual %h", test_name,
                  $sampled(exp_head), $sampled(beat));
      end

   a_beat_port: assert property (@(posedge clk) disable iff (reset)
      (xfer && exp_cnt > 0) |-> (lpbk_vld == exp_head_lpbk))
      else begin
         mism_errs++;
         $display("mismatch %s loopback port expected %0b actual %0b", test_name,
                  $sampled(exp_head_lpbk), $sampled(lpbk_vld));
      end

   a_arb_hold: assert property (@(posedge clk) disable iff (reset)
      (arb_vld && !arb_rdy) |=> (arb_vld && $stable(beat)))
      else begin
         other_errs++;
         $display("error in %s: arbiter beat changed while waiting", test_name);
      end

   a_lpbk_hold: assert property (@(posedge clk) disable iff (reset)
      (lpbk_vld && !lpbk_rdy) |=> (lpbk_vld && $stable(beat)))
      else begin
         other_errs++;
         $display("error in %s: loopback beat changed while waiting", test_name);
      end

   a_port_select: assert property (@(posedge clk) disable iff (reset)
      lpbk_en ? !arb_vld : !lpbk_vld)
      else begin
         other_errs++;
         $display("error in %s: valid raised on the unselected port", test_name);
      end

   //------------------------------------------------------------------------
   // Host side tasks, called on a falling edge
   //------------------------------------------------------------------------
   task automatic host_write(input logic addr, input logic [63:0] data,
                             input logic [7:0] be);
      req.write  = 1'b1;
      req.addr   = addr;
      req.wrdata = data;
      req.byteen = be;
      while (waitreq)
         @(negedge clk);
      @(negedge clk);
      req.write = 1'b0;
   endtask

   task automatic send_pkt(input int nwr, input logic [7:0] last_be, input bit keep);
      st_beat_t    words[$];
      st_beat_t    w;
      logic [7:0]  be;
      logic [31:0] hi;
      logic [31:0] lo;
      pkt_num++;
      host_write(1'b0, 64'h1, 8'h01);
      for (int i = 0; i < nwr; i++) begin
         be = (i == nwr - 1) ? last_be : 8'hff;
         hi = {pkt_num[7:0], 8'h5a, 16'(2 * i)};
         lo = {pkt_num[7:0], 8'ha5, 16'(2 * i + 1)};
         host_write(1'b1, {hi, lo}, be);
         w      = '0;
         w.sop  = (i == 0);
         w.data = hi;
         w.mod  = trailing_empty(be[7:4]);
         words.push_back(w);
         if (be[3]) begin
            w.sop  = 1'b0;
            w.data = lo;
            w.mod  = trailing_empty(be[3:0]);
            words.push_back(w);
         end
      end
      host_write(1'b0, 64'h2, 8'h01);
      if (keep) begin
         for (int k = 0; k < words.size(); k++) begin
            w     = words[k];
            w.eop = (k == words.size() - 1);
            if (!w.eop)
               w.mod = '0;
            exp_q.push_back(w);
            exp_port_q.push_back(lpbk_en);
         end
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() > 0)
         @(negedge clk);
      repeat (8) @(negedge clk);
   endtask

   //------------------------------------------------------------------------
   // Watchdog
   //------------------------------------------------------------------------
   initial begin
      #(TIMEOUT_NS);
      $display("timeout in %s: run did not finish, errors: %0d mismatch, %0d other",
               test_name, mism_errs, other_errs);
      $display("** FAIL **");
      $finish;
   end

   //------------------------------------------------------------------------
   // Test sequence
   //------------------------------------------------------------------------
   initial begin
      reset    = 1'b1;
      req      = '0;
      ch_en    = 1'b1;
      lpbk_en  = 1'b0;
      arb_rdy  = 1'b0;
      lpbk_rdy = 1'b0;
      len_rng  = xorshift32(32'h2f49_376d);
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);

      test_name = "passthrough";
      arb_rdy   = 1'b1;
      send_pkt(4, 8'hff, 1);
      send_pkt(5, 8'hfe, 1);
      send_pkt(3, 8'hf0, 1);
      send_pkt(6, 8'hc0, 1);
      send_pkt(3, 8'hfc, 1);
      send_pkt(2, 8'hfe, 1);
      wait_drain();

      test_name = "loopback";
      lpbk_en   = 1'b1;
      rand_rdy  = 1'b1;
      send_pkt(4, 8'hff, 1);
      send_pkt(7, 8'hf8, 1);
      wait_drain();
      rand_rdy = 1'b0;
      arb_rdy  = 1'b1;
      lpbk_rdy = 1'b1;
      lpbk_en  = 1'b0;
      send_pkt(3, 8'hff, 1);
      wait_drain();

      test_name = "drop_short";
      send_pkt(1, 8'hff, 0);
      send_pkt(3, 8'hff, 1);
      wait_drain();
      test_name = "drop_second_write";
      send_pkt(2, 8'hf0, 0);
      send_pkt(3, 8'hfe, 1);
      wait_drain();
      test_name = "drop_long";
      send_pkt(`IPT_MAX_DATA_WR + 1, 8'hff, 0);
      send_pkt(4, 8'hff, 1);
      wait_drain();
      test_name = "drop_channel_off";
      ch_en = 1'b0;
      send_pkt(3, 8'hff, 0);
      ch_en = 1'b1;
      repeat (3) @(negedge clk);
      send_pkt(3, 8'hff, 1);
      wait_drain();

      test_name = "random_ready";
      rand_rdy  = 1'b1;
      for (int p = 0; p < 6; p++) begin
         len_rng = xorshift32(len_rng);
         send_pkt(3 + int'(len_rng[7:0] % 7), 8'hff << len_rng[9:8], 1);
      end
      wait_drain();
      rand_rdy = 1'b0;
      @(negedge clk);

      test_name = "full_buffer";
      arb_rdy   = 1'b0;
      for (int p = 0; p < 7; p++)
         send_pkt(40, 8'hff, p < 6);
      repeat (20) @(negedge clk);
      arb_rdy = 1'b1;
      wait_drain();
      send_pkt(3, 8'hff, 1);
      wait_drain();

      $display("errors: %0d mismatch, %0d other", mism_errs, other_errs);
      if (mism_errs == 0 && other_errs == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: logic/ncsi_ipt.sv
// NC-SI ingress passthrough top level
// Host writes packets over the slave port, committed packets stream out
// on the arbiter port or on the loopback port as lpbk_en selects
// Single channel only, the slave port is write-only
`timescale 1ns/1ps
`include "ipt_defs.svh"

module ncsi_ipt
   import ipt_bus_pkg::*, ipt_buf_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  avmm_req_t req,
   output logic      waitreq,
   input  logic      ch_en,
   input  logic      lpbk_en,
   output st_beat_t  beat,
   output logic      arb_vld,
   input  logic      arb_rdy,
   output logic      lpbk_vld,
   input  logic      lpbk_rdy
);

   logic     wr_en;
   buf_ptr_t wr_addr;
   st_beat_t wr_word;
   buf_ptr_t commit_ptr;
   buf_ptr_t rd_ptr;
   buf_ptr_t rd_addr;
   st_beat_t rd_word;

   //--------------------------------------------------------------------------
   // Writer, buffer, reader
   //--------------------------------------------------------------------------
   ipt_rx_writer ipt_rx_writer_inst (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .waitreq    (waitreq),
      .ch_en      (ch_en),
      .lpbk_en    (lpbk_en),
      .rd_ptr     (rd_ptr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_word    (wr_word),
      .commit_ptr (commit_ptr)
   );

   ipt_pkt_ram ipt_pkt_ram_inst (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_word (wr_word),
      .rd_addr (rd_addr),
      .rd_word (rd_word)
   );

   ipt_tx_reader ipt_tx_reader_inst (
      .clk        (clk),
      .reset      (reset),
      .commit_ptr (commit_ptr),
      .rd_word    (rd_word),
      .rd_addr    (rd_addr),
      .rd_ptr     (rd_ptr),
      .lpbk_en    (lpbk_en),
      .arb_rdy    (arb_rdy),
      .lpbk_rdy   (lpbk_rdy),
      .beat       (beat),
      .arb_vld    (arb_vld),
      .lpbk_vld   (lpbk_vld)
   );

endmodule

// File: logic/ipt_tx_reader.sv
// Transmit side of the passthrough buffer
// Only one beat is in flight, so throughput is one beat per four cycles
// The loopback enable should only change between packets
`timescale 1ns/1ps
`include "ipt_defs.svh"

module ipt_tx_reader
   import ipt_bus_pkg::*, ipt_buf_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  buf_ptr_t commit_ptr,
   input  st_beat_t rd_word,
   output buf_ptr_t rd_addr,
   output buf_ptr_t rd_ptr,
   input  logic     lpbk_en,
   input  logic     arb_rdy,
   input  logic     lpbk_rdy,
   output st_beat_t beat,
   output logic     arb_vld,
   output logic     lpbk_vld
);

   logic buf_empty;
   logic tx_wip;
   logic rd_en;
   logic rd_en_q1;
   logic rd_en_q2;
   logic tx_vld;
   logic sel_rdy;
   logic xfer;
   logic tx_start;

   //--------------------------------------------------------------------------
   // Port steering
   //--------------------------------------------------------------------------
   always_comb begin
      sel_rdy  = lpbk_en ? lpbk_rdy : arb_rdy;
      xfer     = tx_vld && sel_rdy;
      // Word at the read pointer opens a committed packet
      tx_start = !buf_empty && rd_word.sop;
      rd_addr  = rd_ptr;
      arb_vld  = tx_vld && !lpbk_en;
      lpbk_vld = tx_vld && lpbk_en;
   end

   //--------------------------------------------------------------------------
   // Read control
   //--------------------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         buf_empty <= 1'b1;
         tx_wip    <= 1'b0;
         rd_ptr    <= '0;
         rd_en     <= 1'b0;
         rd_en_q1  <= 1'b0;
         rd_en_q2  <= 1'b0;
         tx_vld    <= 1'b0;
      end else begin
         buf_empty <= (commit_ptr == rd_ptr);

         if (xfer && beat.eop)
            tx_wip <= 1'b0;
         else if (tx_start)
            tx_wip <= 1'b1;

         if (xfer)
            rd_ptr <= rd_ptr + 1'b1;

         // First read on packet start, then one read per transfer
         rd_en    <= (!tx_wip && tx_start) || (tx_wip && xfer && !beat.eop);
         rd_en_q1 <= rd_en;
         rd_en_q2 <= rd_en_q1;

         if (tx_wip && rd_en_q2)
            tx_vld <= 1'b1;
         else if (sel_rdy)
            tx_vld <= 1'b0;
      end
   end

   // Output beat, mod only meaningful on eop
   always_ff @(posedge clk) begin
      if (rd_en_q2) begin
         beat     <= rd_word;
         beat.mod <= rd_word.eop ? rd_word.mod : mod_t'(0);
      end
   end

   // A beat waiting on back-pressure stays put
   a_beat_hold: assert property (@(posedge clk) disable iff (reset)
      (tx_vld && !sel_rdy) |=> (tx_vld && $stable(beat)));

endmodule

// File: logic/ipt_pkt_ram.sv
// Simple dual-port packet buffer, one write and one read port
// Read data appears two cycles after the address
// Wrap bit of both pointers is ignored here
`timescale 1ns/1ps
`include "ipt_defs.svh"

module ipt_pkt_ram
   import ipt_bus_pkg::*, ipt_buf_pkg::*;
(
   input  logic     clk,
   input  logic     wr_en,
   input  buf_ptr_t wr_addr,
   input  st_beat_t wr_word,
   input  buf_ptr_t rd_addr,
   output st_beat_t rd_word
);

   st_beat_t             mem [0:`IPT_WORDS-1];
   logic [`IPT_AWID-1:0] rd_addr_q;

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr[`IPT_AWID-1:0]] <= wr_word;
   end

   // Registered address, then registered data
   always_ff @(posedge clk) begin
      rd_addr_q <= rd_addr[`IPT_AWID-1:0];
      rd_word   <= mem[rd_addr_q];
   end

endmodule

// File: logic/ipt_rx_writer.sv
// Receive side of the passthrough buffer
// Host sees waitreq for one cycle after every accepted write
// A packet is visible to the reader only once its eop is committed
// Dropped packets rewind the write pointer to the packet start
`timescale 1ns/1ps
`include "ipt_defs.svh"

module ipt_rx_writer
   import ipt_bus_pkg::*, ipt_buf_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  avmm_req_t req,
   output logic      waitreq,
   input  logic      ch_en,
   input  logic      lpbk_en,
   input  buf_ptr_t  rd_ptr,
   output logic      wr_en,
   output buf_ptr_t  wr_addr,
   output st_beat_t  wr_word,
   output buf_ptr_t  commit_ptr
);

   localparam int CNT_W = $clog2(`IPT_MAX_DATA_WR + 2);

   rx_state_t          state;
   rx_state_t          state_nxt;
   logic               wr_acc;
   logic               fc_sop;
   logic               fc_eop;
   logic               dat_vld;
   logic               dat_vld_q;
   logic [`IPT_DW-1:0] lo_data;
   logic [3:0]         lo_be;
   logic               sop_pend;
   logic [CNT_W-1:0]   wr_cnt;
   logic               drop_pkt;
   logic               skip_eop;
   buf_ptr_t           wr_tgt;
   logic               buf_full;

   // Byte enables of a 32-bit half to count of empty trailing bytes
   function automatic mod_t be2mod(input logic [3:0] be);
      mod_t m;
      if (be == 4'hf)
         m = 2'd0;
      else if (be[3:1] == 3'h7)
         m = 2'd1;
      else if (be[3:2] == 2'h3)
         m = 2'd2;
      else if (be[3])
         m = 2'd3;
      else
         m = 2'd0;
      return m;
   endfunction

   //--------------------------------------------------------------------------
   // Request decode and full test
   //--------------------------------------------------------------------------
   always_comb begin
      wr_acc  = req.write && !waitreq;
      fc_sop  = wr_acc && !req.addr && req.byteen[0] && req.wrdata[0];
      fc_eop  = wr_acc && !req.addr && req.byteen[0] && req.wrdata[1];
      dat_vld = wr_acc && req.addr;
      // Address the next buffer write will land on
      wr_tgt   = wr_addr + buf_ptr_t'(wr_en);
      buf_full = (wr_tgt[`IPT_AWID-1:0] == rd_ptr[`IPT_AWID-1:0]) &&
                 (wr_tgt[`IPT_AWID] != rd_ptr[`IPT_AWID]);
   end

   // One wait cycle per write, one more while eop is stamped
   always_ff @(posedge clk, posedge reset) begin
      if (reset)
         waitreq <= 1'b1;
      else
         waitreq <= wr_acc || (state == RX_EOP);
   end

   //--------------------------------------------------------------------------
   // Receive FSM
   //--------------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         RX_RESET: begin
            state_nxt = RX_IDLE;
         end
         RX_IDLE: begin
            if (fc_sop)
               state_nxt = RX_PLD;
         end
         RX_PLD: begin
            if ((buf_full && (dat_vld || dat_vld_q)) || drop_pkt)
               state_nxt = RX_DROP;
            else if (fc_eop)
               state_nxt = RX_EOP;
         end
         RX_EOP: begin
            // Short packet is only known here
            state_nxt = drop_pkt ? RX_DROP : RX_IDLE;
         end
         RX_DROP: begin
            if (fc_eop || skip_eop)
               state_nxt = RX_IDLE;
         end
         default: begin
            state_nxt = RX_RESET;
         end
      endcase
   end

   //--------------------------------------------------------------------------
   // Control state and write pointer
   //--------------------------------------------------------------------------
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state      <= RX_RESET;
         dat_vld_q  <= 1'b0;
         sop_pend   <= 1'b0;
         wr_cnt     <= '0;
         drop_pkt   <= 1'b0;
         skip_eop   <= 1'b0;
         commit_ptr <= '0;
         wr_en      <= 1'b0;
         wr_addr    <= '0;
      end else begin
         state     <= state_nxt;
         // Lower half becomes a word only with byte enable 3
         dat_vld_q <= dat_vld && req.byteen[3];

         if (wr_en)
            sop_pend <= 1'b0;
         else if (state == RX_IDLE)
            sop_pend <= 1'b1;

         if (state == RX_IDLE)
            wr_cnt <= '0;
         else if (dat_vld)
            wr_cnt <= wr_cnt + 1'b1;

         // Channel off, too short, bad second write, too long
         drop_pkt <= (!ch_en && !lpbk_en) ||
                     (fc_eop && wr_cnt < 2) ||
                     (dat_vld && wr_cnt == 1 && req.byteen[7:1] != 7'h7f) ||
                     (dat_vld && wr_cnt >= `IPT_MAX_DATA_WR);

         skip_eop <= (state == RX_EOP) && drop_pkt;

         if (state == RX_IDLE)
            commit_ptr <= wr_addr;

         wr_en <= (((state == RX_PLD) && (dat_vld || dat_vld_q) && !buf_full) ||
                   (state == RX_EOP)) && !drop_pkt;

         // Eop is stamped onto the word just below the pointer
         if (state == RX_DROP)
            wr_addr <= commit_ptr;
         else if (state == RX_EOP)
            wr_addr <= wr_addr - 1'b1;
         else if (wr_en)
            wr_addr <= wr_addr + 1'b1;
      end
   end

   //--------------------------------------------------------------------------
   // Buffer word assembly
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (dat_vld) begin
         lo_data <= req.wrdata[`IPT_DW-1:0];
         lo_be   <= req.byteen[3:0];
      end

      if (state == RX_EOP) begin
         wr_word.eop <= 1'b1;
      end else if (dat_vld_q) begin
         wr_word.sop  <= 1'b0;
         wr_word.eop  <= 1'b0;
         wr_word.mod  <= be2mod(lo_be);
         wr_word.data <= lo_data;
      end else if (dat_vld) begin
         wr_word.sop  <= sop_pend;
         wr_word.eop  <= 1'b0;
         wr_word.mod  <= be2mod(req.byteen[7:4]);
         wr_word.data <= req.wrdata[2*`IPT_DW-1:`IPT_DW];
      end
   end

   // Nothing of a discarded packet reaches the buffer
   a_no_wr_in_drop: assert property (@(posedge clk) disable iff (reset)
      (state == RX_DROP) |-> !wr_en);

   a_state_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot(state));

endmodule

// File: logic/ipt_buf_pkg.sv
// Packet buffer pointer and receive FSM types
// Pointers carry one wrap bit above the word address
// so a full buffer and an empty one can be told apart
`include "ipt_defs.svh"

package ipt_buf_pkg;

   // Word pointer with wrap bit on top
   typedef logic [`IPT_AWID:0] buf_ptr_t;

   // Receive FSM, one-hot
   typedef enum logic [4:0] {
      RX_RESET = 5'b00001,
      RX_IDLE  = 5'b00010,
      RX_PLD   = 5'b00100,
      RX_EOP   = 5'b01000,
      RX_DROP  = 5'b10000
   } rx_state_t;

endpackage

// File: logic/ipt_bus_pkg.sv
// Host slave request and outgoing stream beat types
// One host data write carries one or two stream words
// The stream beat layout doubles as the buffer word layout
`include "ipt_defs.svh"

package ipt_bus_pkg;

   // Empty trailing bytes of the last word in a packet
   typedef logic [1:0] mod_t;

   // One request from the management host
   typedef struct packed {
      logic                   write;
      logic                   addr;     // 0 flow control, 1 packet data
      logic [2*`IPT_DW-1:0]   wrdata;
      logic [2*`IPT_DW/8-1:0] byteen;
   } avmm_req_t;

   // One stream beat, also one word of the packet buffer
   typedef struct packed {
      logic               sop;
      logic               eop;
      mod_t               mod;
      logic [`IPT_DW-1:0] data;
   } st_beat_t;

endpackage

// File: logic/ipt_defs.svh
// Sizing for the ingress passthrough buffer and packet limits
// Buffer size must be a power of two and a multiple of four bytes
// Packet length is enforced in 8-byte host writes, not in bytes
`ifndef IPT_DEFS_SVH
`define IPT_DEFS_SVH

// Packet buffer storage in bytes
`define IPT_BUFR_BYTES 2048

// Buffer depth in 32-bit words
`define IPT_WORDS (`IPT_BUFR_BYTES / 4)

// Word address width, the pointer wrap bit comes on top of this
`define IPT_AWID $clog2(`IPT_WORDS)

// Longest packet the host may send, in bytes
`define IPT_MAX_PKT_LEN 1522

// Data writes allowed per packet, length rounded up to 8-byte units
`define IPT_MAX_DATA_WR ((`IPT_MAX_PKT_LEN + 7) / 8)

// Stream and buffer word data width
`define IPT_DW 32

`endif
